// ==== hdl/beam_pkg.sv ====
package beam_pkg;

    // array geometry
    localparam int NCHAN = 8;
    localparam int NSAMP = 4;
    localparam int NBITS = 5;

    // datapath widths
    localparam int SB_BITS = 7;
    localparam int BEAM_BITS = 9;
    localparam int POWER_BITS = 18;

    localparam int NBEAMS = 4;
    localparam int NTHRESH = 2;

    // sample words kept per channel, newest included
    localparam int STORE_DEPTH = 2;

    localparam int NUM_LEFT_ADDERS = 2;
    localparam int NUM_RIGHT_ADDERS = 2;
    localparam int NUM_TOP_ADDERS = 2;

    typedef logic signed [NBITS-1:0] sample_t;
    typedef logic [NSAMP*NBITS-1:0] sample_word_t;
    typedef logic [NSAMP*SB_BITS-1:0] sb_word_t;
    typedef logic [POWER_BITS-1:0] power_t;
    typedef logic [POWER_BITS-1:0] thresh_t;

    // antennas feeding each adder type
    localparam int LEFT_CHANNELS[0:2] = '{5, 6, 7};
    localparam int RIGHT_CHANNELS[0:2] = '{1, 2, 3};
    localparam int TOP_CHANNELS[0:1] = '{0, 4};

    // tap delay in samples per adder and input, 0 to NSAMP
    localparam int LEFT_DELAYS[0:NUM_LEFT_ADDERS-1][0:2] = '{
        '{0, 1, 2},
        '{2, 1, 0}
    };
    localparam int RIGHT_DELAYS[0:NUM_RIGHT_ADDERS-1][0:2] = '{
        '{0, 2, 4},
        '{4, 2, 0}
    };
    localparam int TOP_DELAYS[0:NUM_TOP_ADDERS-1][0:1] = '{
        '{0, 0},
        '{3, 1}
    };

    // left, right and top adder used by each beam
    localparam int BEAM_INDICES[0:NBEAMS-1][0:2] = '{
        '{0, 0, 0},
        '{0, 1, 1},
        '{1, 0, 1},
        '{1, 1, 0}
    };

    // lowest bit of the window that ends delay samples before the newest one
    function automatic int tap_lsb(input int delay);
        return ((STORE_DEPTH - 1) * NSAMP - delay) * NBITS;
    endfunction

endpackage

// ==== hdl/sample_store.sv ====
`timescale 1ns/1ps

module sample_store
    import beam_pkg::*;
(
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  sample_word_t                   dat_i,
    output sample_word_t [STORE_DEPTH-1:0] store_o
);

    // word STORE_DEPTH-1 is the newest, word 0 the oldest
    sample_word_t [STORE_DEPTH-1:0] hist_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            hist_q <= '0;
        end else begin
            hist_q[STORE_DEPTH-1] <= dat_i;
            for (int i = 0; i < STORE_DEPTH - 1; i++) begin
                hist_q[i] <= hist_q[i+1];
            end
        end
    end

    // flat view keeps samples in time order from low to high bits,
    // so a tap window can run across a word boundary
    assign store_o = hist_q;

endmodule

// ==== hdl/sub_beam.sv ====
`timescale 1ns/1ps

module sub_beam
    import beam_pkg::*;
(
    input  logic         clk_i,
    input  sample_word_t cha_i,
    input  sample_word_t chb_i,
    input  sample_word_t chc_i,
    output sb_word_t     dat_o
);

    sb_word_t sum_d;
    sb_word_t sum_q;

    // three 5-bit samples never overflow 7 bits
    always_comb begin
        logic signed [SB_BITS-1:0] acc;
        sample_t                   a;
        sample_t                   b;
        sample_t                   c;
        for (int s = 0; s < NSAMP; s++) begin
            a = cha_i[s*NBITS +: NBITS];
            b = chb_i[s*NBITS +: NBITS];
            c = chc_i[s*NBITS +: NBITS];
            acc = a + b + c;
            sum_d[s*SB_BITS +: SB_BITS] = acc;
        end
    end

    always_ff @(posedge clk_i) begin
        sum_q <= sum_d;
    end

    assign dat_o = sum_q;

endmodule

// ==== hdl/beam_power.sv ====
`timescale 1ns/1ps

module beam_power
    import beam_pkg::*;
(
    input  logic     clk_i,
    input  sb_word_t left_i,
    input  sb_word_t right_i,
    input  sb_word_t top_i,
    output power_t   power_o
);

    logic signed [BEAM_BITS-1:0] beam_d [NSAMP];
    logic signed [BEAM_BITS-1:0] beam_q [NSAMP];
    power_t                      power_d;
    power_t                      power_q;

    // stage one: beam sample is the sum of the three sub-beams
    always_comb begin
        logic signed [SB_BITS-1:0] l;
        logic signed [SB_BITS-1:0] r;
        logic signed [SB_BITS-1:0] t;
        for (int s = 0; s < NSAMP; s++) begin
            l = left_i[s*SB_BITS +: SB_BITS];
            r = right_i[s*SB_BITS +: SB_BITS];
            t = top_i[s*SB_BITS +: SB_BITS];
            beam_d[s] = l + r + t;
        end
    end

    always_ff @(posedge clk_i) begin
        for (int s = 0; s < NSAMP; s++) begin
            beam_q[s] <= beam_d[s];
        end
    end

    // stage two: squares are never negative, so the sum is taken unsigned
    always_comb begin
        logic signed [2*BEAM_BITS-1:0] sq;
        power_d = '0;
        for (int s = 0; s < NSAMP; s++) begin
            sq = beam_q[s] * beam_q[s];
            power_d = power_d + power_t'(sq);
        end
    end

    always_ff @(posedge clk_i) begin
        power_q <= power_d;
    end

    assign power_o = power_q;

endmodule

// ==== hdl/threshold_ctrl.sv ====
`timescale 1ns/1ps

module threshold_ctrl
    import beam_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  thresh_t [NTHRESH-1:0]     thresh_i,
    input  logic [NTHRESH-1:0]        thresh_wr_i,
    input  logic [NTHRESH-1:0]        thresh_update_i,
    input  power_t [NBEAMS-1:0]       power_i,
    output logic [NTHRESH*NBEAMS-1:0] trigger_o
);

    thresh_t                   stage_q [NTHRESH];
    thresh_t                   active_q [NTHRESH];
    logic [NTHRESH*NBEAMS-1:0] trigger_q;

    // an update on the same edge as a write takes the previous staging value
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int k = 0; k < NTHRESH; k++) begin
                stage_q[k] <= '1;
                active_q[k] <= '1;
            end
        end else begin
            for (int k = 0; k < NTHRESH; k++) begin
                if (thresh_wr_i[k]) begin
                    stage_q[k] <= thresh_i[k];
                end
                if (thresh_update_i[k]) begin
                    active_q[k] <= stage_q[k];
                end
            end
        end
    end

    // bit k*NBEAMS+b is beam b against threshold k
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            trigger_q <= '0;
        end else begin
            for (int k = 0; k < NTHRESH; k++) begin
                for (int b = 0; b < NBEAMS; b++) begin
                    trigger_q[k*NBEAMS + b] <= (power_i[b] > active_q[k]);
                end
            end
        end
    end

    assign trigger_o = trigger_q;

endmodule

// ==== hdl/beamform_trigger.sv ====
`timescale 1ns/1ps

module beamform_trigger
    import beam_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  sample_word_t [NCHAN-1:0]  data_i,
    input  thresh_t [NTHRESH-1:0]     thresh_i,
    input  logic [NTHRESH-1:0]        thresh_wr_i,
    input  logic [NTHRESH-1:0]        thresh_update_i,
    output logic [NTHRESH*NBEAMS-1:0] trigger_o
);

    // per-channel history, oldest sample in the low bits
    logic [STORE_DEPTH*NSAMP*NBITS-1:0] store [NCHAN];

    sb_word_t left_sb [NUM_LEFT_ADDERS];
    sb_word_t right_sb [NUM_RIGHT_ADDERS];
    sb_word_t top_sb [NUM_TOP_ADDERS];

    power_t [NBEAMS-1:0] beam_pwr;

    generate
        for (genvar ch = 0; ch < NCHAN; ch++) begin : g_store
            sample_store u_store (
                .clk_i   (clk_i),
                .reset_i (reset_i),
                .dat_i   (data_i[ch]),
                .store_o (store[ch])
            );
        end

        // left triplets
        for (genvar l = 0; l < NUM_LEFT_ADDERS; l++) begin : g_left
            sample_word_t tap [3];
            for (genvar c = 0; c < 3; c++) begin : g_tap
                assign tap[c] =
                    store[LEFT_CHANNELS[c]][tap_lsb(LEFT_DELAYS[l][c]) +: NSAMP*NBITS];
            end
            sub_beam u_sb (
                .clk_i (clk_i),
                .cha_i (tap[0]),
                .chb_i (tap[1]),
                .chc_i (tap[2]),
                .dat_o (left_sb[l])
            );
        end

        // right triplets
        for (genvar r = 0; r < NUM_RIGHT_ADDERS; r++) begin : g_right
            sample_word_t tap [3];
            for (genvar c = 0; c < 3; c++) begin : g_tap
                assign tap[c] =
                    store[RIGHT_CHANNELS[c]][tap_lsb(RIGHT_DELAYS[r][c]) +: NSAMP*NBITS];
            end
            sub_beam u_sb (
                .clk_i (clk_i),
                .cha_i (tap[0]),
                .chb_i (tap[1]),
                .chc_i (tap[2]),
                .dat_o (right_sb[r])
            );
        end

        // top doublets, third adder input is unused
        for (genvar t = 0; t < NUM_TOP_ADDERS; t++) begin : g_top
            sample_word_t tap [2];
            for (genvar c = 0; c < 2; c++) begin : g_tap
                assign tap[c] =
                    store[TOP_CHANNELS[c]][tap_lsb(TOP_DELAYS[t][c]) +: NSAMP*NBITS];
            end
            sub_beam u_sb (
                .clk_i (clk_i),
                .cha_i (tap[0]),
                .chb_i (tap[1]),
                .chc_i ('0),
                .dat_o (top_sb[t])
            );
        end

        // sub-beams go straight to the beams with no extra offset
        for (genvar b = 0; b < NBEAMS; b++) begin : g_beam
            beam_power u_power (
                .clk_i   (clk_i),
                .left_i  (left_sb[BEAM_INDICES[b][0]]),
                .right_i (right_sb[BEAM_INDICES[b][1]]),
                .top_i   (top_sb[BEAM_INDICES[b][2]]),
                .power_o (beam_pwr[b])
            );
        end
    endgenerate

    threshold_ctrl u_ctrl (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .thresh_i        (thresh_i),
        .thresh_wr_i     (thresh_wr_i),
        .thresh_update_i (thresh_update_i),
        .power_i         (beam_pwr),
        .trigger_o       (trigger_o)
    );

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o
);

    // 40 ns period, starts low
    initial begin
        clk_o = 1'b0;
        forever begin
            #20 clk_o = ~clk_o;
        end
    end

endmodule

// ==== verification/beamform_trigger_assertions.sv ====
`timescale 1ns/1ps

module beamform_trigger_assertions
    import beam_pkg::*;
(
    input logic                      clk_i,
    input logic                      reset_i,
    input logic [NTHRESH-1:0]        thresh_wr_i,
    input logic [NTHRESH-1:0]        thresh_update_i,
    input logic [NTHRESH*NBEAMS-1:0] trigger_i
);

    logic               upd_seen;
    logic [NTHRESH-1:0] wr_seen;

    int unsigned reset_fails;
    int unsigned rise_fails;
    int unsigned idle0_fails;
    int unsigned idle1_fails;
    int unsigned fail_count;

    // history of threshold traffic since the last reset
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            upd_seen <= 1'b0;
            wr_seen <= '0;
        end else begin
            if (|thresh_update_i) begin
                upd_seen <= 1'b1;
            end
            wr_seen <= wr_seen | thresh_wr_i;
        end
    end

    assign fail_count = reset_fails + rise_fails + idle0_fails + idle1_fails;

    reset_clears: assert property (@(posedge clk_i) reset_i |=> (trigger_i == '0))
        else begin
            $error("trigger_o was not cleared during or right after reset");
            reset_fails++;
        end

    // thresholds stay all ones until an update copies a staged value
    rise_needs_update: assert property (@(posedge clk_i) disable iff (reset_i)
        ((trigger_i & ~$past(trigger_i)) != '0) |-> upd_seen)
        else begin
            $error("trigger bit rose with no threshold update since reset");
            rise_fails++;
        end

    idle_update0: assert property (@(posedge clk_i) disable iff (reset_i)
        (thresh_update_i[0] && !wr_seen[0]) |-> ##2 (trigger_i[NBEAMS-1:0] == '0))
        else begin
            $error("update of unwritten threshold 0 raised a trigger");
            idle0_fails++;
        end

    idle_update1: assert property (@(posedge clk_i) disable iff (reset_i)
        (thresh_update_i[1] && !wr_seen[1]) |-> ##2 (trigger_i[2*NBEAMS-1:NBEAMS] == '0))
        else begin
            $error("update of unwritten threshold 1 raised a trigger");
            idle1_fails++;
        end

endmodule

// ==== verification/beamform_trigger_tb.sv ====
`timescale 1ns/1ps

module beamform_trigger_tb
    import beam_pkg::*;
;

    localparam int RESET_CYCLES = 5;
    localparam int SETTLE_CYCLES = 8;
    localparam int NRANDOM = 6;

    typedef logic [NCHAN-1:0][NBITS-1:0] chan_vals_t;

    logic                      clk_i;
    logic                      reset_i;
    sample_word_t [NCHAN-1:0]  data_i;
    thresh_t [NTHRESH-1:0]     thresh_i;
    logic [NTHRESH-1:0]        thresh_wr_i;
    logic [NTHRESH-1:0]        thresh_update_i;
    logic [NTHRESH*NBEAMS-1:0] trigger_o;

    // stimulus and expected values, one entry per row
    string                     name_q [$];
    chan_vals_t                chans_q [$];
    thresh_t [NTHRESH-1:0]     th_q [$];
    logic [NTHRESH-1:0]        wr_q [$];
    logic [NTHRESH-1:0]        upd_q [$];
    logic [NTHRESH*NBEAMS-1:0] exp_q [$];

    // reference threshold registers
    thresh_t model_stage [NTHRESH];
    thresh_t model_active [NTHRESH];

    int seed;
    int check_count;
    int error_count;
    int assert_fails;

    tb_clock u_clock (
        .clk_o (clk_i)
    );

    beamform_trigger beamform_trigger_i (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .data_i          (data_i),
        .thresh_i        (thresh_i),
        .thresh_wr_i     (thresh_wr_i),
        .thresh_update_i (thresh_update_i),
        .trigger_o       (trigger_o)
    );

    bind beamform_trigger beamform_trigger_assertions u_assertions (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .thresh_wr_i     (thresh_wr_i),
        .thresh_update_i (thresh_update_i),
        .trigger_i       (trigger_o)
    );

    // every beam uses each antenna once, so a steady input sums all channels
    function automatic int beam_power_model(input chan_vals_t chans);
        sample_t v;
        int      total;
        total = 0;
        for (int c = 0; c < NCHAN; c++) begin
            v = chans[c];
            total = total + v;
        end
        return NSAMP * total * total;
    endfunction

    // spread a channel sum as evenly as possible over the antennas
    function automatic chan_vals_t chans_for_sum(input int total);
        chan_vals_t chans;
        int         base;
        int         rest;
        int         v;
        base = total / NCHAN;
        rest = total - base * NCHAN;
        for (int c = 0; c < NCHAN; c++) begin
            v = base;
            if (rest > 0 && c < rest) begin
                v = base + 1;
            end else if (rest < 0 && c < -rest) begin
                v = base - 1;
            end
            chans[c] = v[NBITS-1:0];
        end
        return chans;
    endfunction

    task automatic add_row(input string name, input chan_vals_t chans, input thresh_t th0,
                           input thresh_t th1, input logic [NTHRESH-1:0] wr,
                           input logic [NTHRESH-1:0] upd);
        thresh_t                   th [NTHRESH];
        int                        power;
        logic [NTHRESH*NBEAMS-1:0] exp_trig;
        th[0] = th0;
        th[1] = th1;
        power = beam_power_model(chans);
        // update first, so a write on the same edge is not seen yet
        for (int k = 0; k < NTHRESH; k++) begin
            if (upd[k]) begin
                model_active[k] = model_stage[k];
            end
            if (wr[k]) begin
                model_stage[k] = th[k];
            end
        end
        exp_trig = '0;
        for (int k = 0; k < NTHRESH; k++) begin
            for (int b = 0; b < NBEAMS; b++) begin
                exp_trig[k*NBEAMS + b] = (power_t'(power) > model_active[k]);
            end
        end
        name_q.push_back(name);
        chans_q.push_back(chans);
        th_q.push_back({th1, th0});
        wr_q.push_back(wr);
        upd_q.push_back(upd);
        exp_q.push_back(exp_trig);
    endtask

    task automatic build_table();
        chan_vals_t         chans;
        int                 rnd;
        thresh_t            th0;
        thresh_t            th1;
        logic [NTHRESH-1:0] wr;
        logic [NTHRESH-1:0] upd;
        for (int k = 0; k < NTHRESH; k++) begin
            model_stage[k] = '1;
            model_active[k] = '1;
        end
        add_row("reset_idle_pos", chans_for_sum(120), 0, 0, 2'b00, 2'b00);
        add_row("reset_idle_neg", chans_for_sum(-128), 0, 0, 2'b00, 2'b00);
        add_row("update_unwritten", chans_for_sum(120), 0, 0, 2'b00, 2'b11);
        add_row("write_no_update", chans_for_sum(10), 399, 400, 2'b11, 2'b00);
        add_row("update_just_above", chans_for_sum(10), 0, 0, 2'b00, 2'b11);
        add_row("power_above_both", chans_for_sum(11), 0, 0, 2'b00, 2'b00);
        add_row("write_and_update", chans_for_sum(12), 1000, 100, 2'b11, 2'b11);
        add_row("independent_halves", chans_for_sum(12), 0, 0, 2'b00, 2'b11);
        add_row("negative_sum", chans_for_sum(-12), 0, 0, 2'b00, 2'b00);
        add_row("write_equal", chans_for_sum(-12), 576, 0, 2'b01, 2'b00);
        add_row("update_equal", chans_for_sum(-12), 0, 0, 2'b00, 2'b01);
        add_row("negative_above", chans_for_sum(-13), 0, 0, 2'b00, 2'b00);
        add_row("positive_above", chans_for_sum(13), 0, 0, 2'b00, 2'b00);
        seed = 32'hb981_75ca;
        for (int r = 0; r < NRANDOM; r++) begin
            for (int c = 0; c < NCHAN; c++) begin
                rnd = $random(seed);
                chans[c] = rnd[NBITS-1:0];
            end
            rnd = $random(seed);
            th0 = thresh_t'($unsigned(rnd) % 70000);
            rnd = $random(seed);
            th1 = thresh_t'($unsigned(rnd) % 70000);
            rnd = $random(seed);
            wr = rnd[1:0];
            upd = rnd[3:2];
            add_row($sformatf("random_%0d", r), chans, th0, th1, wr, upd);
        end
    endtask

    task automatic apply_row(input int idx);
        @(posedge clk_i);
        for (int ch = 0; ch < NCHAN; ch++) begin
            data_i[ch] <= {NSAMP{chans_q[idx][ch]}};
        end
        thresh_i <= th_q[idx];
        thresh_wr_i <= wr_q[idx];
        thresh_update_i <= upd_q[idx];
        // strobes last one cycle, data stay until the next row
        for (int n = 0; n < SETTLE_CYCLES; n++) begin
            @(posedge clk_i);
            thresh_wr_i <= '0;
            thresh_update_i <= '0;
        end
        @(negedge clk_i);
        check_count++;
        assert (trigger_o === exp_q[idx])
            else begin
                $display("Error %s: expected %h, actual %h", name_q[idx], exp_q[idx],
                         trigger_o);
                error_count++;
            end
    endtask

    initial begin
        reset_i = 1'b1;
        data_i = '0;
        thresh_i = '0;
        thresh_wr_i = '0;
        thresh_update_i = '0;
        check_count = 0;
        error_count = 0;
        build_table();
        for (int n = 0; n < RESET_CYCLES; n++) begin
            @(posedge clk_i);
        end
        reset_i <= 1'b0;
        for (int i = 0; i < name_q.size(); i++) begin
            apply_row(i);
        end
        assert_fails = beamform_trigger_i.u_assertions.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
hdl/beam_pkg.sv
hdl/sample_store.sv
hdl/sub_beam.sv
hdl/beam_power.sv
hdl/threshold_ctrl.sv
hdl/beamform_trigger.sv
verification/tb_clock.sv
verification/beamform_trigger_assertions.sv
verification/beamform_trigger_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := beamform_trigger_tb
FILELIST  := sim.f
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SIM_ARGS  := +verilator+error+limit+100
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
